//--- sim.f
hw/mem_ctrl_pkg.sv
hw/port_req_if.sv
hw/cmd_if.sv
hw/wb_port_slave.sv
hw/port_arbiter.sv
hw/cmd_fifo.sv
hw/avl_master.sv
hw/mem_ctrl_top.sv
test/avl_mem_model.sv
test/tb_mem_ctrl.sv

//--- Bender.yml
package:
  name: mem_ctrl

sources:
  - files:
      - hw/mem_ctrl_pkg.sv
      - hw/port_req_if.sv
      - hw/cmd_if.sv
      - hw/wb_port_slave.sv
      - hw/port_arbiter.sv
      - hw/cmd_fifo.sv
      - hw/avl_master.sv
      - hw/mem_ctrl_top.sv
  - target: test
    files:
      - test/avl_mem_model.sv
      - test/tb_mem_ctrl.sv

//--- test/tb_mem_ctrl.sv
module tb_mem_ctrl;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_PORTS      = 2;
  localparam int SEED         = 80613;
  localparam int RESET_CYCLES = 16;
  localparam int ACK_TIMEOUT  = 500;
  localparam int N_RANDOM     = 300;
  localparam int N_POSTED     = 6;
  localparam int HOLD_CYCLES  = 40;
  localparam int REGION_LINES = 16;

  logic clk = 1'b0;
  logic rst = 1'b1;

  logic [N_PORTS-1:0]                  wb_cyc   = '0;
  logic [N_PORTS-1:0]                  wb_stb   = '0;
  logic [N_PORTS-1:0]                  wb_we    = '0;
  mem_ctrl_pkg::wb_adr_t [N_PORTS-1:0] wb_adr   = '0;
  mem_ctrl_pkg::line_t [N_PORTS-1:0]   wb_dat_w = '0;
  logic [N_PORTS-1:0]                  wb_ack;
  mem_ctrl_pkg::line_t [N_PORTS-1:0]   wb_dat_r;

  logic                    avl_ready;
  mem_ctrl_pkg::line_adr_t avl_addr;
  mem_ctrl_pkg::line_t     avl_wdata;
  logic                    avl_read;
  logic                    avl_write;
  logic                    avl_rdata_valid;
  mem_ctrl_pkg::line_t     avl_rdata;
  logic                    hold_ready = 1'b0;
  int                      avl_writes;

  // Reference model with one region of lines per port
  mem_ctrl_pkg::line_t ref_line  [N_PORTS][REGION_LINES];
  bit                  ref_valid [N_PORTS][REGION_LINES];
  int                  write_acks = 0;

  always #2 clk = ~clk;

  mem_ctrl_top #(
    .N_PORTS (N_PORTS)
  ) mem_ctrl_top_inst (
    .clk               (clk),
    .rst               (rst),
    .wb_cyc_i          (wb_cyc),
    .wb_stb_i          (wb_stb),
    .wb_we_i           (wb_we),
    .wb_adr_i          (wb_adr),
    .wb_dat_i          (wb_dat_w),
    .wb_ack_o          (wb_ack),
    .wb_dat_o          (wb_dat_r),
    .avl_ready_i       (avl_ready),
    .avl_addr_o        (avl_addr),
    .avl_wdata_o       (avl_wdata),
    .avl_read_o        (avl_read),
    .avl_write_o       (avl_write),
    .avl_rdata_valid_i (avl_rdata_valid),
    .avl_rdata_i       (avl_rdata)
  );

  avl_mem_model avl_mem_model_inst (
    .clk               (clk),
    .rst               (rst),
    .hold_ready_i      (hold_ready),
    .avl_ready_o       (avl_ready),
    .avl_addr_i        (avl_addr),
    .avl_wdata_i       (avl_wdata),
    .avl_read_i        (avl_read),
    .avl_write_i       (avl_write),
    .avl_rdata_valid_o (avl_rdata_valid),
    .avl_rdata_o       (avl_rdata),
    .write_count_o     (avl_writes)
  );

  // ********************
  // Helpers
  // ********************

  task automatic fail_msg(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic fail_value(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
    $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  function automatic mem_ctrl_pkg::line_t expected_fill(input mem_ctrl_pkg::line_adr_t adr);
    mem_ctrl_pkg::line_t l;
    for (int k = 0; k < 4; k++)
      l[32*k +: 32] = {6'(k), adr} ^ 32'h9e37_79b9;
    return l;
  endfunction

  function automatic mem_ctrl_pkg::line_t rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic mem_ctrl_pkg::line_adr_t line_of(input int p, input int idx);
    return mem_ctrl_pkg::line_adr_t'((p + 1) * 'h1000 + idx);
  endfunction

  // One classic cycle that ends at the edge after ack with stb dropped
  task automatic wb_access(input int p, input logic we, input mem_ctrl_pkg::line_adr_t adr,
                           input mem_ctrl_pkg::line_t wdat, output mem_ctrl_pkg::line_t rdat);
    mem_ctrl_pkg::wb_adr_t wa;
    int                    waited;
    // Bits outside the line field carry noise
    wa = mem_ctrl_pkg::wb_adr_t'($urandom);
    wa[mem_ctrl_pkg::LINE_MSB:mem_ctrl_pkg::LINE_LSB] = adr;
    waited = 0;
    @(posedge clk);
    wb_cyc[p]   <= 1'b1;
    wb_stb[p]   <= 1'b1;
    wb_we[p]    <= we;
    wb_adr[p]   <= wa;
    wb_dat_w[p] <= wdat;
    @(negedge clk);
    while (!wb_ack[p])
    begin
      waited++;
      if (waited > ACK_TIMEOUT)
        fail_msg($sformatf("No ack on port %0d within %0d cycles", p, ACK_TIMEOUT));
      @(negedge clk);
    end
    rdat = wb_dat_r[p];
    if (we)
      write_acks++;
    @(posedge clk);
    wb_cyc[p] <= 1'b0;
    wb_stb[p] <= 1'b0;
  endtask

  task automatic do_write(input int p, input int idx);
    mem_ctrl_pkg::line_t data;
    mem_ctrl_pkg::line_t rd_ignored;
    data = rand_line();
    wb_access(p, 1'b1, line_of(p, idx), data, rd_ignored);
    ref_line[p][idx]  = data;
    ref_valid[p][idx] = 1'b1;
  endtask

  task automatic do_read_check(input int p, input int idx);
    mem_ctrl_pkg::line_t got;
    mem_ctrl_pkg::line_t exp;
    wb_access(p, 1'b0, line_of(p, idx), '0, got);
    exp = ref_valid[p][idx] ? ref_line[p][idx] : expected_fill(line_of(p, idx));
    assert (got === exp)
    else
      fail_value($sformatf("wb_dat_o[%0d]", p), got, exp);
  endtask

  task automatic random_traffic(input int p, input int n);
    int idx;
    for (int i = 0; i < n; i++)
    begin
      idx = $urandom_range(0, REGION_LINES - 1);
      repeat ($urandom_range(0, 2)) @(posedge clk);
      if ($urandom_range(0, 1) == 1)
        do_write(p, idx);
      else
        do_read_check(p, idx);
    end
  endtask

  task automatic post_writes(input int p, input int n);
    for (int i = 0; i < n; i++)
      do_write(p, $urandom_range(0, REGION_LINES - 1));
  endtask

  task automatic read_region(input int p);
    for (int idx = 0; idx < REGION_LINES; idx++)
      do_read_check(p, idx);
  endtask

  // ********************
  // Monitors
  // ********************

  // Outputs stay quiet in reset and one cycle after
  bit rst_d = 1'b1;
  always @(negedge clk)
  begin
    if (rst || rst_d)
    begin
      assert (wb_ack === '0)
      else
        fail_value("wb_ack_o", wb_ack, '0);
      assert (avl_read === 1'b0)
      else
        fail_value("avl_read_o", avl_read, '0);
      assert (avl_write === 1'b0)
      else
        fail_value("avl_write_o", avl_write, '0);
    end
    rst_d = rst;
  end

  always @(negedge clk)
  begin
    if (!rst)
    begin
      for (int p = 0; p < N_PORTS; p++)
      begin
        if (wb_ack[p])
        begin
          assert (wb_stb[p])
          else
            fail_msg($sformatf("Ack on port %0d without a pending request", p));
        end
      end
    end
  end

  // A command held off by ready must not change
  bit                      cmd_held = 1'b0;
  logic                    held_rd;
  logic                    held_wr;
  mem_ctrl_pkg::line_adr_t held_addr;
  mem_ctrl_pkg::line_t     held_wdata;
  always @(negedge clk)
  begin
    if (!rst)
    begin
      assert (!(avl_read && avl_write))
      else
        fail_msg("Avalon read and write asserted together");
      if (cmd_held)
      begin
        assert (avl_read === held_rd)
        else
          fail_value("avl_read_o", avl_read, held_rd);
        assert (avl_write === held_wr)
        else
          fail_value("avl_write_o", avl_write, held_wr);
        assert (avl_addr === held_addr)
        else
          fail_value("avl_addr_o", avl_addr, held_addr);
        assert (avl_wdata === held_wdata)
        else
          fail_value("avl_wdata_o", avl_wdata, held_wdata);
      end
    end
    cmd_held   = !rst && (avl_read || avl_write) && !avl_ready;
    held_rd    = avl_read;
    held_wr    = avl_write;
    held_addr  = avl_addr;
    held_wdata = avl_wdata;
  end

  // ********************
  // Stimulus
  // ********************

  initial
  begin
    void'($urandom(SEED));
    for (int p = 0; p < N_PORTS; p++)
      for (int idx = 0; idx < REGION_LINES; idx++)
        ref_valid[p][idx] = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // Write and read back one line and read one never written
    do_write(0, 3);
    do_read_check(0, 3);
    do_read_check(1, 5);

    fork
      random_traffic(0, N_RANDOM);
      random_traffic(1, N_RANDOM);
    join

    // Slave stalls while both ports post writes
    hold_ready <= 1'b1;
    fork
      begin
        repeat (HOLD_CYCLES) @(posedge clk);
        hold_ready <= 1'b0;
      end
      post_writes(0, N_POSTED);
      post_writes(1, N_POSTED);
    join

    // Reads queue behind every posted write
    fork
      read_region(0);
      read_region(1);
    join

    assert (avl_writes == write_acks)
    else
      fail_value("avl_write_o count", avl_writes, write_acks);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- test/avl_mem_model.sv
module avl_mem_model (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    hold_ready_i,

  output logic                    avl_ready_o,
  input  mem_ctrl_pkg::line_adr_t avl_addr_i,
  input  mem_ctrl_pkg::line_t     avl_wdata_i,
  input  logic                    avl_read_i,
  input  logic                    avl_write_i,
  output logic                    avl_rdata_valid_o,
  output mem_ctrl_pkg::line_t     avl_rdata_o,

  output int                      write_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  mem_ctrl_pkg::line_t     mem [mem_ctrl_pkg::line_adr_t];
  logic                    read_pend;
  int                      lat;
  mem_ctrl_pkg::line_adr_t pend_adr;

  // Contents of a line that was never written
  function automatic mem_ctrl_pkg::line_t init_line(input mem_ctrl_pkg::line_adr_t adr);
    mem_ctrl_pkg::line_t l;
    for (int k = 0; k < 4; k++)
      l[32*k +: 32] = {6'(k), adr} ^ 32'h9e37_79b9;
    return l;
  endfunction

  initial
  begin
    avl_ready_o       = 1'b0;
    avl_rdata_valid_o = 1'b0;
    avl_rdata_o       = '0;
    write_count_o     = 0;
    read_pend         = 1'b0;
    lat               = 0;
    pend_adr          = '0;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      avl_ready_o       <= 1'b0;
      avl_rdata_valid_o <= 1'b0;
      read_pend         <= 1'b0;
      write_count_o     <= 0;
    end
    else
    begin
      // Random wait states, one cycle in four
      avl_ready_o       <= hold_ready_i ? 1'b0 : ($urandom_range(0, 3) != 0);
      avl_rdata_valid_o <= 1'b0;
      if (avl_ready_o && avl_write_i)
      begin
        mem[avl_addr_i] = avl_wdata_i;
        write_count_o <= write_count_o + 1;
      end
      if (read_pend)
      begin
        if (lat == 1)
        begin
          avl_rdata_valid_o <= 1'b1;
          avl_rdata_o       <= mem.exists(pend_adr) ? mem[pend_adr] : init_line(pend_adr);
          read_pend         <= 1'b0;
        end
        else
          lat <= lat - 1;
      end
      if (avl_ready_o && avl_read_i)
      begin
        read_pend <= 1'b1;
        pend_adr  <= avl_addr_i;
        lat       <= $urandom_range(1, 8);
      end
    end
  end

endmodule

//--- hw/mem_ctrl_top.sv
module mem_ctrl_top #(
  parameter int N_PORTS    = 2,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                rst,

  // Wishbone ports
  input  logic [N_PORTS-1:0]                  wb_cyc_i,
  input  logic [N_PORTS-1:0]                  wb_stb_i,
  input  logic [N_PORTS-1:0]                  wb_we_i,
  input  mem_ctrl_pkg::wb_adr_t [N_PORTS-1:0] wb_adr_i,
  input  mem_ctrl_pkg::line_t [N_PORTS-1:0]   wb_dat_i,
  output logic [N_PORTS-1:0]                  wb_ack_o,
  output mem_ctrl_pkg::line_t [N_PORTS-1:0]   wb_dat_o,

  // Avalon-MM master
  input  logic                                avl_ready_i,
  output mem_ctrl_pkg::line_adr_t             avl_addr_o,
  output mem_ctrl_pkg::line_t                 avl_wdata_o,
  output logic                                avl_read_o,
  output logic                                avl_write_o,
  input  logic                                avl_rdata_valid_i,
  input  mem_ctrl_pkg::line_t                 avl_rdata_i
);

  port_req_if port_req [N_PORTS] ();
  cmd_if      arb_cmd ();
  cmd_if      avl_cmd ();

  logic                rd_valid;
  mem_ctrl_pkg::line_t rd_data;

  // ********************
  // Port adapters
  // ********************

  for (genvar g = 0; g < N_PORTS; g++)
  begin : gen_port
    wb_port_slave wb_port_slave_inst (
      .clk      (clk),
      .rst      (rst),
      .wb_cyc_i (wb_cyc_i[g]),
      .wb_stb_i (wb_stb_i[g]),
      .wb_we_i  (wb_we_i[g]),
      .wb_adr_i (wb_adr_i[g]),
      .wb_dat_i (wb_dat_i[g]),
      .wb_ack_o (wb_ack_o[g]),
      .wb_dat_o (wb_dat_o[g]),
      .req      (port_req[g])
    );
  end

  port_arbiter #(
    .N_PORTS (N_PORTS)
  ) port_arbiter_inst (
    .clk      (clk),
    .rst      (rst),
    .ports    (port_req),
    .cmd      (arb_cmd),
    .rvalid_i (rd_valid),
    .rdata_i  (rd_data)
  );

  cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) cmd_fifo_inst (
    .clk (clk),
    .rst (rst),
    .wr  (arb_cmd),
    .rd  (avl_cmd)
  );

  avl_master avl_master_inst (
    .clk               (clk),
    .rst               (rst),
    .cmd               (avl_cmd),
    .avl_ready_i       (avl_ready_i),
    .avl_addr_o        (avl_addr_o),
    .avl_wdata_o       (avl_wdata_o),
    .avl_read_o        (avl_read_o),
    .avl_write_o       (avl_write_o),
    .avl_rdata_valid_i (avl_rdata_valid_i),
    .avl_rdata_i       (avl_rdata_i),
    .rvalid_o          (rd_valid),
    .rdata_o           (rd_data)
  );

endmodule

//--- hw/avl_master.sv
module avl_master (
  input  logic                    clk,
  input  logic                    rst,

  cmd_if.dst                      cmd,

  input  logic                    avl_ready_i,
  output mem_ctrl_pkg::line_adr_t avl_addr_o,
  output mem_ctrl_pkg::line_t     avl_wdata_o,
  output logic                    avl_read_o,
  output logic                    avl_write_o,
  input  logic                    avl_rdata_valid_i,
  input  mem_ctrl_pkg::line_t     avl_rdata_i,

  output logic                    rvalid_o,
  output mem_ctrl_pkg::line_t     rdata_o
);

  typedef enum logic [1:0] {idle, issue, wait_data} state_t;

  state_t state_q;
  logic   pop;

  // A write taken by the slave lets the next entry pop in the same cycle
  assign cmd.ready = (state_q == idle) |
                     ((state_q == issue) & avl_ready_i & avl_write_o);
  assign pop = cmd.valid & cmd.ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= idle;
      avl_read_o  <= 1'b0;
      avl_write_o <= 1'b0;
      rvalid_o    <= 1'b0;
    end
    else
    begin
      rvalid_o <= 1'b0;
      case (state_q)
        idle:
          if (pop)
          begin
            avl_read_o  <= ~cmd.we;
            avl_write_o <= cmd.we;
            state_q     <= issue;
          end
        issue:
          if (avl_ready_i)
          begin
            if (pop)
            begin
              avl_read_o  <= ~cmd.we;
              avl_write_o <= cmd.we;
            end
            else
            begin
              avl_read_o  <= 1'b0;
              avl_write_o <= 1'b0;
              state_q     <= avl_read_o ? wait_data : idle;
            end
          end
        wait_data:
          if (avl_rdata_valid_i)
          begin
            rvalid_o <= 1'b1;
            state_q  <= idle;
          end
        default:
          state_q <= idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      avl_addr_o  <= cmd.adr;
      avl_wdata_o <= cmd.wdata;
    end
    if (state_q == wait_data && avl_rdata_valid_i)
      rdata_o <= avl_rdata_i;
  end

endmodule

//--- hw/cmd_fifo.sv
module cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic clk,
  input  logic rst,

  cmd_if.dst   wr,
  cmd_if.src   rd
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic                    mem_we    [FIFO_DEPTH];
  mem_ctrl_pkg::line_adr_t mem_adr   [FIFO_DEPTH];
  mem_ctrl_pkg::line_t     mem_wdata [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty = (count_q == '0);
  assign push  = wr.valid & ~full;
  assign pop   = rd.ready & ~empty;

  assign wr.ready = ~full;
  assign rd.valid = ~empty;
  assign rd.we    = mem_we[rd_ptr_q];
  assign rd.adr   = mem_adr[rd_ptr_q];
  assign rd.wdata = mem_wdata[rd_ptr_q];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem_we[wr_ptr_q]    <= wr.we;
      mem_adr[wr_ptr_q]   <= wr.adr;
      mem_wdata[wr_ptr_q] <= wr.wdata;
    end
  end

endmodule

//--- hw/port_arbiter.sv
module port_arbiter #(
  parameter int N_PORTS = 2
) (
  input  logic                clk,
  input  logic                rst,

  port_req_if.arb             ports [N_PORTS],
  cmd_if.src                  cmd,

  input  logic                rvalid_i,
  input  mem_ctrl_pkg::line_t rdata_i
);

  localparam int IDX_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

  typedef logic [IDX_W-1:0] port_idx_t;

  logic [N_PORTS-1:0]      req_v;
  logic [N_PORTS-1:0]      we_v;
  mem_ctrl_pkg::line_adr_t adr_v   [N_PORTS];
  mem_ctrl_pkg::line_t     wdata_v [N_PORTS];
  logic [N_PORTS-1:0]      eligible;
  logic [N_PORTS-1:0]      grant_v;

  port_idx_t ptr_q;
  port_idx_t sel_idx;
  logic      sel_found;
  logic      push;
  port_idx_t owner_q;
  logic      rd_busy_q;

  for (genvar g = 0; g < N_PORTS; g++)
  begin : gen_port
    assign req_v[g]   = ports[g].req;
    assign we_v[g]    = ports[g].we;
    assign adr_v[g]   = ports[g].adr;
    assign wdata_v[g] = ports[g].wdata;

    assign ports[g].grant  = grant_v[g];
    assign ports[g].rvalid = rvalid_i & rd_busy_q & (owner_q == port_idx_t'(g));
    assign ports[g].rdata  = rdata_i;
  end

  // Reads wait while another read is outstanding, writes never do
  assign eligible = req_v & (we_v | {N_PORTS{~rd_busy_q}});

  // ********************
  // Round-robin search
  // ********************

  always_comb
  begin
    int idx;
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int k = 0; k < N_PORTS; k++)
    begin
      idx = int'(ptr_q) + k;
      if (idx >= N_PORTS)
        idx = idx - N_PORTS;
      if (!sel_found && eligible[idx])
      begin
        sel_found = 1'b1;
        sel_idx   = port_idx_t'(idx);
      end
    end
  end

  assign push = sel_found & cmd.ready;

  always_comb
  begin
    grant_v = '0;
    if (push)
      grant_v[sel_idx] = 1'b1;
  end

  assign cmd.valid = push;
  assign cmd.we    = we_v[sel_idx];
  assign cmd.adr   = adr_v[sel_idx];
  assign cmd.wdata = wdata_v[sel_idx];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ptr_q     <= '0;
      owner_q   <= '0;
      rd_busy_q <= 1'b0;
    end
    else
    begin
      // Next search starts after the granted port
      if (push)
        ptr_q <= (sel_idx == port_idx_t'(N_PORTS - 1)) ? '0 : sel_idx + 1'b1;
      if (push && !we_v[sel_idx])
      begin
        owner_q   <= sel_idx;
        rd_busy_q <= 1'b1;
      end
      else if (rvalid_i)
        rd_busy_q <= 1'b0;
    end
  end

endmodule

//--- hw/wb_port_slave.sv
module wb_port_slave (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  mem_ctrl_pkg::wb_adr_t wb_adr_i,
  input  mem_ctrl_pkg::line_t   wb_dat_i,
  output logic                  wb_ack_o,
  output mem_ctrl_pkg::line_t   wb_dat_o,

  port_req_if.port              req
);

  typedef enum logic [1:0] {idle, wait_grant, wait_data} state_t;

  state_t                  state_q;
  logic                    start;
  logic                    we_q;
  mem_ctrl_pkg::line_adr_t adr_q;
  mem_ctrl_pkg::line_t     wdata_q;
  mem_ctrl_pkg::line_t     rdata_q;

  // stb is ignored in the ack cycle
  assign start = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  assign req.req   = (state_q == wait_grant);
  assign req.we    = we_q;
  assign req.adr   = adr_q;
  assign req.wdata = wdata_q;

  assign wb_dat_o = rdata_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q  <= idle;
      wb_ack_o <= 1'b0;
    end
    else
    begin
      wb_ack_o <= 1'b0;
      case (state_q)
        idle:
          if (start)
            state_q <= wait_grant;
        wait_grant:
          if (req.grant)
          begin
            // Writes are posted, so ack as soon as they are queued
            if (we_q)
            begin
              wb_ack_o <= 1'b1;
              state_q  <= idle;
            end
            else
              state_q <= wait_data;
          end
        wait_data:
          if (req.rvalid)
          begin
            wb_ack_o <= 1'b1;
            state_q  <= idle;
          end
        default:
          state_q <= idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == idle && start)
    begin
      we_q    <= wb_we_i;
      adr_q   <= wb_adr_i[mem_ctrl_pkg::LINE_MSB:mem_ctrl_pkg::LINE_LSB];
      wdata_q <= wb_dat_i;
    end
    if (req.rvalid)
      rdata_q <= req.rdata;
  end

endmodule

//--- hw/cmd_if.sv
interface cmd_if;

  logic                    valid;
  logic                    ready;
  logic                    we;
  mem_ctrl_pkg::line_adr_t adr;
  mem_ctrl_pkg::line_t     wdata;

  // Transfer on valid and ready both high
  modport src (
    output valid, we, adr, wdata,
    input  ready
  );

  modport dst (
    input  valid, we, adr, wdata,
    output ready
  );

endinterface

//--- hw/port_req_if.sv
interface port_req_if;

  // Request side, driven by the port adapter
  logic                    req;
  logic                    we;
  mem_ctrl_pkg::line_adr_t adr;
  mem_ctrl_pkg::line_t     wdata;

  // Response side, driven by the arbiter
  logic                    grant;
  logic                    rvalid;
  mem_ctrl_pkg::line_t     rdata;

  modport port (
    output req, we, adr, wdata,
    input  grant, rvalid, rdata
  );

  modport arb (
    input  req, we, adr, wdata,
    output grant, rvalid, rdata
  );

endinterface

//--- hw/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

  // ********************
  // Widths
  // ********************

  localparam int LINE_W    = 128;
  localparam int WB_ADR_W  = 32;
  localparam int AVL_ADR_W = 26;

  // ********************
  // Address mapping
  // ********************

  // Line address is a slice of the Wishbone byte address
  localparam int LINE_LSB = 4;
  localparam int LINE_MSB = LINE_LSB + AVL_ADR_W - 1;

  // ********************
  // Types
  // ********************

  typedef logic [LINE_W-1:0]    line_t;
  typedef logic [WB_ADR_W-1:0]  wb_adr_t;
  typedef logic [AVL_ADR_W-1:0] line_adr_t;

endpackage
